// ==== filelist.f ====
+incdir+include
verilog/klLoaderPkg.sv
verilog/asciiFieldDecoder.sv
verilog/groupCounter.sv
verilog/wordAssembler.sv
verilog/loadSequencer.sv
verilog/klLoaderTop.sv
tb/klLoaderTb.sv

// ==== include/klLoader_cfg.svh ====
// Sizes and character codes of the KL10 microcode RAM loader
`ifndef KL_LOADER_CFG_SVH
`define KL_LOADER_CFG_SVH

////////////////////////////////////////
// Word and group sizes
////////////////////////////////////////

// One decoded PDP-11 word
`define FIELD_WIDTH 16
// Field words per CRAM word
`define CRAM_GROUP 6
// Field words per DRAM even/odd pair
`define DRAM_GROUP 3

////////////////////////////////////////
// RAM geometry
////////////////////////////////////////

`define CRAM_ADDR_WIDTH 11
`define DRAM_ADDR_WIDTH 9
`define CRAM_WORD_WIDTH 86

// Load file character codes
`define CHAR_COMMA 8'h2c
`define CHAR_NEWLINE 8'h0a
`define CHAR_SEMICOLON 8'h3b

`endif

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the loader testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -f filelist.f --top-module klLoaderTb -Mdir obj_dir \
  > build.log 2>&1 \
  && ./obj_dir/VklLoaderTb > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or run did not complete"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && exit 1
exit 0

// ==== tb/klLoaderTb.sv ====
// Testbench for the KL10 microcode RAM loader with random load file lines and a write model
`include "klLoader_cfg.svh"

module klLoaderTb;

  timeunit 1ns;
  timeprecision 1ps;

  import klLoaderPkg::*;

  logic clk;
  logic rstN;
  logic charValid;
  logic [7:0] charData;
  logic charReady;
  logic cramWrValid;
  tCramWrite cramWr;
  logic cramWrReady;
  logic dramWrValid;
  tDramWrite dramWr;
  logic dramWrReady;
  logic lineDone;
  logic lineError;
  logic loadEnd;

  // Expected writes and {lineDone, lineError, loadEnd} per line
  tCramWrite cramExp[$];
  tDramWrite dramExp[$];
  logic [2:0] statusExp[$];
  // Characters of the line being built
  byte lineChars[$];

  int charsSent = 0;
  int readyLowPct = 25;
  int checkCount = 0;
  int errCount = 0;
  int errAtStart = 0;
  int testsRun = 0;
  int testsPassed = 0;

  klLoaderTop dut (
    .clk         (clk),
    .rstN        (rstN),
    .charValid   (charValid),
    .charData    (charData),
    .charReady   (charReady),
    .cramWrValid (cramWrValid),
    .cramWr      (cramWr),
    .cramWrReady (cramWrReady),
    .dramWrValid (dramWrValid),
    .dramWr      (dramWr),
    .dramWrReady (dramWrReady),
    .lineDone    (lineDone),
    .lineError   (lineError),
    .loadEnd     (loadEnd)
  );

  // 40 ns period
  always #20 clk = ~clk;

  ////////////////////////////////////////
  // Checking and bookkeeping
  ////////////////////////////////////////

  task automatic checkValue(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
    checkCount++;
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errCount++;
    end
  endtask

  task automatic startTest();
    errAtStart = errCount;
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    if (errCount == errAtStart) begin
      testsPassed++;
      $display("Test %0d %s: ok", testsRun, name);
    end else begin
      $display("Test %0d %s: FAILED with %0d errors", testsRun, name, errCount - errAtStart);
    end
  endtask

  // Write streams see random stalls, heavier when readyLowPct is raised
  always @(negedge clk) begin
    cramWrReady = (($urandom % 100) >= readyLowPct);
    dramWrReady = (($urandom % 100) >= readyLowPct);
  end

  // CRAM write monitor
  always @(posedge clk) begin : cramMonitor
    tCramWrite e;
    if (rstN && cramWrValid && cramWrReady) begin
      if (cramExp.size() == 0) begin
        $display("Error at %0t ns: a CRAM write came out when none was expected", $time);
        errCount++;
      end else begin
        e = cramExp.pop_front();
        checkValue("cramWr", 128'(cramWr), 128'(e));
      end
    end
  end

  // DRAM write monitor
  always @(posedge clk) begin : dramMonitor
    tDramWrite e;
    if (rstN && dramWrValid && dramWrReady) begin
      if (dramExp.size() == 0) begin
        $display("Error at %0t ns: a DRAM write came out when none was expected", $time);
        errCount++;
      end else begin
        e = dramExp.pop_front();
        checkValue("dramWr", 128'(dramWr), 128'(e));
      end
    end
  end

  // Line status monitor
  always @(posedge clk) begin : statusMonitor
    logic [2:0] e;
    if (rstN && (lineDone || lineError || loadEnd)) begin
      if (statusExp.size() == 0) begin
        $display("Error at %0t ns: a line status pulse came with no line ending", $time);
        errCount++;
      end else begin
        e = statusExp.pop_front();
        checkValue("lineStatus", 128'({lineDone, lineError, loadEnd}), 128'(e));
      end
    end
  end

  ////////////////////////////////////////
  // Line encoding and driving
  ////////////////////////////////////////

  // Values below octal 75 move up by octal 100
  function automatic byte asciiize(input logic [5:0] v);
    if (v < 6'o75) begin
      return byte'({2'b01, v});
    end else begin
      return byte'({2'b00, v});
    end
  endfunction

  task automatic beginLine(input byte recType);
    lineChars.delete();
    lineChars.push_back(recType);
    lineChars.push_back(" ");
  endtask

  // Three characters per word, then comma or newline
  task automatic addField(input tFieldWord w, input bit isLast);
    lineChars.push_back(asciiize({2'b00, w[15:12]}));
    lineChars.push_back(asciiize(w[11:6]));
    lineChars.push_back(asciiize(w[5:0]));
    if (isLast) begin
      lineChars.push_back(`CHAR_NEWLINE);
    end else begin
      lineChars.push_back(`CHAR_COMMA);
    end
  endtask

  task automatic sendChar(input byte c);
    int gap;
    gap = 0;
    if (($urandom % 4) == 0) begin
      gap = int'($urandom % 4) + 1;
    end
    repeat (gap) begin
      @(negedge clk);
      charValid = 1'b0;
    end
    @(negedge clk);
    charValid = 1'b1;
    charData = c;
    @(posedge clk);
    while (!charReady) begin
      @(posedge clk);
    end
    charsSent++;
  endtask

  task automatic sendLine();
    int i;
    for (i = 0; i < lineChars.size(); i++) begin
      sendChar(lineChars[i]);
    end
    @(negedge clk);
    charValid = 1'b0;
  endtask

  // Results are done once every expected event has been seen
  task automatic waitDrained();
    while (cramExp.size() != 0 || dramExp.size() != 0 || statusExp.size() != 0) begin
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////
  // Line generators and model
  ////////////////////////////////////////

  task automatic runRecordLine(input byte recType, input int groups, input bit corrupt);
    tFieldWord data[$];
    tFieldWord wc;
    tFieldWord adr;
    tFieldWord sum;
    tFieldWord chk;
    tCramWrite cramE;
    tDramWrite dramE;
    int size;
    int i;
    size = (recType == "C") ? `CRAM_GROUP : `DRAM_GROUP;
    wc = 16'(groups * size);
    // DRAM pairs start on an even address
    if (recType == "C") begin
      adr = 16'($urandom % 2048);
    end else begin
      adr = 16'(($urandom % 256) * 2);
    end
    sum = wc + adr;
    for (i = 0; i < groups * size; i++) begin
      data.push_back(16'($urandom));
      sum = sum + data[i];
    end
    for (i = 0; i < groups; i++) begin
      if (recType == "C") begin
        cramE.addr = 11'(adr + 16'(i));
        cramE.data = '0;
        // Load order 64-79, 48-63, 32-47, 16-31, 0-15, 80-85
        cramE.data[64:79] = data[6 * i];
        cramE.data[48:63] = data[6 * i + 1];
        cramE.data[32:47] = data[6 * i + 2];
        cramE.data[16:31] = data[6 * i + 3];
        cramE.data[0:15] = data[6 * i + 4];
        cramE.data[80:85] = data[6 * i + 5][5:0];
        cramExp.push_back(cramE);
      end else begin
        dramE.addr = 9'(adr + 16'(2 * i));
        dramE.data.even = data[3 * i];
        dramE.data.odd = data[3 * i + 1];
        dramE.data.common = data[3 * i + 2];
        dramExp.push_back(dramE);
      end
    end
    // Negated sum makes the line total zero
    chk = 16'd0 - sum;
    if (corrupt) begin
      chk = chk + 16'(1 + ($urandom % 65535));
    end
    statusExp.push_back({1'b1, corrupt, 1'b0});
    beginLine(recType);
    addField(wc, 1'b0);
    addField(adr, 1'b0);
    for (i = 0; i < data.size(); i++) begin
      addField(data[i], 1'b0);
    end
    addField(chk, 1'b1);
    sendLine();
  endtask

  // Free text after the semicolon, nothing expected
  task automatic runCommentLine();
    int n;
    int i;
    n = int'($urandom % 10) + 3;
    beginLine(`CHAR_SEMICOLON);
    for (i = 0; i < n; i++) begin
      if (($urandom % 5) == 0) begin
        lineChars.push_back(`CHAR_COMMA);
      end else begin
        lineChars.push_back(byte'(8'h61 + 8'($urandom % 26)));
      end
    end
    lineChars.push_back(`CHAR_NEWLINE);
    sendLine();
  endtask

  // Type E to Z, never C or D
  task automatic runUnknownLine();
    int n;
    int i;
    n = int'($urandom % 4) + 1;
    beginLine(byte'(8'h45 + 8'($urandom % 22)));
    for (i = 0; i < n; i++) begin
      addField(16'($urandom), i == n - 1);
    end
    statusExp.push_back(3'b110);
    sendLine();
  endtask

  // Zero word count and empty address
  task automatic runEndLine();
    beginLine("C");
    lineChars.push_back(`CHAR_COMMA);
    lineChars.push_back(`CHAR_COMMA);
    lineChars.push_back(`CHAR_NEWLINE);
    statusExp.push_back(3'b101);
    sendLine();
  endtask

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  // Limit grows with every character sent
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= charsSent * 40 + 2000) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the loader stopped taking characters or producing results");
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : mainSequence
    clk = 1'b0;
    rstN = 1'b0;
    charValid = 1'b0;
    charData = 8'h00;
    cramWrReady = 1'b0;
    dramWrReady = 1'b0;
    void'($urandom(32'h6cb));
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    // Idle state after reset
    startTest();
    checkValue("charReady", 128'(charReady), 128'(1'b1));
    checkValue("cramWrValid", 128'(cramWrValid), 128'(1'b0));
    checkValue("dramWrValid", 128'(dramWrValid), 128'(1'b0));
    repeat (6) runRecordLine("C", int'($urandom % 5) + 1, 1'b0);
    waitDrained();
    finishTest("random C lines");

    startTest();
    repeat (6) runRecordLine("D", int'($urandom % 10) + 1, 1'b0);
    waitDrained();
    finishTest("random D lines");

    startTest();
    runRecordLine("C", int'($urandom % 5) + 1, 1'b1);
    runRecordLine("D", int'($urandom % 10) + 1, 1'b1);
    runRecordLine("C", 2, 1'b0);
    runRecordLine("D", int'($urandom % 10) + 1, 1'b1);
    waitDrained();
    finishTest("bad checksum");

    startTest();
    runCommentLine();
    runUnknownLine();
    runCommentLine();
    runCommentLine();
    runUnknownLine();
    waitDrained();
    finishTest("comment and unknown lines");

    startTest();
    runEndLine();
    waitDrained();
    finishTest("end line");

    // Write outputs mostly stalled
    startTest();
    readyLowPct = 90;
    repeat (3) begin
      runRecordLine("C", 5, 1'b0);
      runRecordLine("D", 10, 1'b0);
    end
    waitDrained();
    readyLowPct = 25;
    finishTest("write back-pressure");

    $display("Tests: %0d run, %0d passed, %0d failed; checks: %0d, errors: %0d",
             testsRun, testsPassed, testsRun - testsPassed, checkCount, errCount);
    if (errCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog/asciiFieldDecoder.sv ====
// Field decoder that turns load file characters into record type, field and end of line tokens
`include "klLoader_cfg.svh"

module asciiFieldDecoder (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   charValid,
  input  logic [7:0]             charData,
  output logic                   charReady,
  output logic                   tokenValid,
  output klLoaderPkg::tFieldToken token,
  input  logic                   tokenReady
);

  import klLoaderPkg::*;

  // Line position
  logic atLineStart;
  logic skipSpace;
  // Field being gathered
  tFieldWord acc;
  logic fieldUsed;
  // Newline came after a non-empty last field
  logic eolPending;

  logic charTake;
  logic tokenTake;
  logic isComma;
  logic isNewline;

  assign charTake = charValid && charReady;
  assign tokenTake = tokenValid && tokenReady;
  assign isComma = (charData == `CHAR_COMMA);
  assign isNewline = (charData == `CHAR_NEWLINE);

  // Hold off characters while a token waits
  assign charReady = !tokenValid;

  ////////////////////////////////////////
  // Control state
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      atLineStart <= 1'b1;
      skipSpace <= 1'b0;
      fieldUsed <= 1'b0;
      eolPending <= 1'b0;
      tokenValid <= 1'b0;
    end else begin
      if (tokenTake) begin
        // End of line token follows the last field directly
        tokenValid <= eolPending;
        eolPending <= 1'b0;
      end
      if (charTake) begin
        if (atLineStart) begin
          atLineStart <= 1'b0;
          skipSpace <= 1'b1;
          tokenValid <= 1'b1;
        end else if (skipSpace) begin
          // Space after the type character
          skipSpace <= 1'b0;
        end else if (isComma) begin
          fieldUsed <= 1'b0;
          tokenValid <= 1'b1;
        end else if (isNewline) begin
          atLineStart <= 1'b1;
          fieldUsed <= 1'b0;
          eolPending <= fieldUsed;
          tokenValid <= 1'b1;
        end else begin
          fieldUsed <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Token and field payload
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (tokenTake && eolPending) begin
      token.kind <= endOfLine;
    end
    if (charTake) begin
      if (atLineStart) begin
        token.kind <= typeChar;
        token.recType <= charData;
        acc <= '0;
      end else if (!skipSpace) begin
        if (isComma || (isNewline && fieldUsed)) begin
          token.kind <= field;
          token.value <= acc;
          acc <= '0;
        end else if (isNewline) begin
          // Empty last field gives only the end of line
          token.kind <= endOfLine;
          acc <= '0;
        end else begin
          // Low six bits per character, most significant first
          acc <= {acc[`FIELD_WIDTH-7:0], charData[5:0]};
        end
      end
    end
  end

endmodule

// ==== verilog/groupCounter.sv ====
// Group counter that splits the data words of a record line into RAM groups
`include "klLoader_cfg.svh"

module groupCounter (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   load,
  input  klLoaderPkg::tFieldWord wordCount,
  input  klLoaderPkg::tGroupKind kind,
  input  logic                   step,
  output logic                   groupDone,
  output logic                   dataDone
);

  import klLoaderPkg::*;

  localparam int posWidth = $clog2(`CRAM_GROUP);

  // Data words still expected on this line
  tFieldWord remaining;
  // Word position inside the current group
  logic [posWidth-1:0] position;
  logic [posWidth-1:0] lastPos;
  tGroupKind groupKind;
  logic stepOk;

  // Six words per CRAM word and three per DRAM pair
  assign lastPos = (groupKind == dram) ? posWidth'(`DRAM_GROUP - 1)
                                       : posWidth'(`CRAM_GROUP - 1);

  // Nothing counts once the data words are used up
  assign stepOk = step && !dataDone;

  // Combinational so the write can start on the same clock
  assign groupDone = stepOk && (position == lastPos);

  // Next field is the checksum
  assign dataDone = (remaining == '0);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      remaining <= '0;
      position <= '0;
      groupKind <= cram;
    end else if (load) begin
      remaining <= wordCount;
      position <= '0;
      groupKind <= kind;
    end else if (stepOk) begin
      remaining <= remaining - 1'b1;
      if (groupDone) begin
        position <= '0;
      end else begin
        position <= position + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/klLoaderPkg.sv ====
// Shared token, payload and write types of the KL10 microcode RAM loader
`include "klLoader_cfg.svh"

package klLoaderPkg;

  ////////////////////////////////////////
  // Field decoder tokens
  ////////////////////////////////////////

  // One decoded ASCIIized field
  typedef logic [`FIELD_WIDTH-1:0] tFieldWord;

  typedef enum logic [1:0] {
    typeChar,
    field,
    endOfLine,
    none
  } tTokenKind;

  // Record type is only meaningful on typeChar tokens
  typedef struct packed {
    tTokenKind  kind;
    logic [7:0] recType;
    tFieldWord  value;
  } tFieldToken;

  ////////////////////////////////////////
  // RAM payloads
  ////////////////////////////////////////

  // Control word, bit 0 on the left as in the KL10 prints
  typedef logic [0:`CRAM_WORD_WIDTH-1] tCramWord;

  // Three words per DRAM pair
  typedef struct packed {
    tFieldWord even;
    tFieldWord odd;
    tFieldWord common;
  } tDramPair;

  typedef logic [`CRAM_ADDR_WIDTH-1:0] tCramAddr;
  typedef logic [`DRAM_ADDR_WIDTH-1:0] tDramAddr;

  // CRAM write request
  typedef struct packed {
    tCramAddr addr;
    tCramWord data;
  } tCramWrite;

  // DRAM pair write, addr is the even location
  typedef struct packed {
    tDramAddr addr;
    tDramPair data;
  } tDramWrite;

  // Selects six or three words per group
  typedef enum logic {
    cram,
    dram
  } tGroupKind;

endpackage

// ==== verilog/klLoaderTop.sv ====
// Top level of the KL10 microcode RAM loader from character stream to CRAM and DRAM writes
module klLoaderTop (
  input  logic                   clk,
  input  logic                   rstN,
  // Load file characters
  input  logic                   charValid,
  input  logic [7:0]             charData,
  output logic                   charReady,
  // CRAM writes
  output logic                   cramWrValid,
  output klLoaderPkg::tCramWrite cramWr,
  input  logic                   cramWrReady,
  // DRAM pair writes
  output logic                   dramWrValid,
  output klLoaderPkg::tDramWrite dramWr,
  input  logic                   dramWrReady,
  // Line status pulses
  output logic                   lineDone,
  output logic                   lineError,
  output logic                   loadEnd
);

  import klLoaderPkg::*;

  // Decoder to sequencer
  logic tokenValid;
  tFieldToken token;
  logic tokenReady;

  // Sequencer to assemblers
  logic shiftEn;
  tFieldWord fieldWord;

  // Sequencer and group counter
  logic counterLoad;
  tFieldWord wordCount;
  tGroupKind groupKind;
  logic counterStep;
  logic groupDone;
  logic dataDone;

  // Assembled payloads
  tCramWord cramPayload;
  tDramPair dramPayload;

  asciiFieldDecoder uDecoder (
    .clk        (clk),
    .rstN       (rstN),
    .charValid  (charValid),
    .charData   (charData),
    .charReady  (charReady),
    .tokenValid (tokenValid),
    .token      (token),
    .tokenReady (tokenReady)
  );

  loadSequencer uSequencer (
    .clk         (clk),
    .rstN        (rstN),
    .tokenValid  (tokenValid),
    .token       (token),
    .tokenReady  (tokenReady),
    .shiftEn     (shiftEn),
    .fieldWord   (fieldWord),
    .counterLoad (counterLoad),
    .wordCount   (wordCount),
    .groupKind   (groupKind),
    .counterStep (counterStep),
    .groupDone   (groupDone),
    .dataDone    (dataDone),
    .cramPayload (cramPayload),
    .dramPayload (dramPayload),
    .cramWrValid (cramWrValid),
    .cramWr      (cramWr),
    .cramWrReady (cramWrReady),
    .dramWrValid (dramWrValid),
    .dramWr      (dramWr),
    .dramWrReady (dramWrReady),
    .lineDone    (lineDone),
    .lineError   (lineError),
    .loadEnd     (loadEnd)
  );

  groupCounter uCounter (
    .clk       (clk),
    .rstN      (rstN),
    .load      (counterLoad),
    .wordCount (wordCount),
    .kind      (groupKind),
    .step      (counterStep),
    .groupDone (groupDone),
    .dataDone  (dataDone)
  );

  // Six words into the CRAM bit ranges
  wordAssembler #(.tPayload(tCramWord)) uCramAssembler (
    .clk       (clk),
    .rstN      (rstN),
    .shiftEn   (shiftEn),
    .fieldWord (fieldWord),
    .payload   (cramPayload)
  );

  // Even, odd and common words of a DRAM pair
  wordAssembler #(.tPayload(tDramPair)) uDramAssembler (
    .clk       (clk),
    .rstN      (rstN),
    .shiftEn   (shiftEn),
    .fieldWord (fieldWord),
    .payload   (dramPayload)
  );

endmodule

// ==== verilog/loadSequencer.sv ====
// Load sequencer FSM that parses record lines, issues RAM writes and checks line checksums
`include "klLoader_cfg.svh"

module loadSequencer (
  input  logic                   clk,
  input  logic                   rstN,
  // Tokens from the field decoder
  input  logic                   tokenValid,
  input  klLoaderPkg::tFieldToken token,
  output logic                   tokenReady,
  // Assembler and counter control
  output logic                   shiftEn,
  output klLoaderPkg::tFieldWord fieldWord,
  output logic                   counterLoad,
  output klLoaderPkg::tFieldWord wordCount,
  output klLoaderPkg::tGroupKind groupKind,
  output logic                   counterStep,
  input  logic                   groupDone,
  input  logic                   dataDone,
  input  klLoaderPkg::tCramWord  cramPayload,
  input  klLoaderPkg::tDramPair  dramPayload,
  // Write streams
  output logic                   cramWrValid,
  output klLoaderPkg::tCramWrite cramWr,
  input  logic                   cramWrReady,
  output logic                   dramWrValid,
  output klLoaderPkg::tDramWrite dramWr,
  input  logic                   dramWrReady,
  // One-cycle line status
  output logic                   lineDone,
  output logic                   lineError,
  output logic                   loadEnd
);

  import klLoaderPkg::*;

  typedef enum logic [2:0] {
    stType,
    stCount,
    stAddress,
    stData,
    stChecksum,
    stSkip,
    stWriteWait
  } tState;

  typedef enum logic [1:0] {
    recCram,
    recDram,
    recComment,
    recUnknown
  } tRecKind;

  tState state;
  tRecKind recKind;
  // Running 16-bit line sum
  tFieldWord sum;
  // RAM address of the next write
  tFieldWord ramAddr;
  // Zero word count seen
  logic endLine;

  logic take;
  logic takeField;
  logic takeEol;
  logic wrTake;

  ////////////////////////////////////////
  // Handshakes and datapath steering
  ////////////////////////////////////////

  // Stall the token stream behind a pending write
  assign tokenReady = (state != stWriteWait);
  assign take = tokenValid && tokenReady;
  assign takeField = take && (token.kind == field);
  assign takeEol = take && (token.kind == endOfLine);
  assign wrTake = (cramWrValid && cramWrReady) || (dramWrValid && dramWrReady);

  // First field loads the counter
  assign counterLoad = takeField && (state == stCount);
  assign wordCount = token.value;
  assign groupKind = (recKind == recDram) ? dram : cram;

  // Data words go to both assemblers, the checksum does not
  assign shiftEn = takeField && (state == stData) && !dataDone;
  assign counterStep = shiftEn;
  assign fieldWord = token.value;

  assign cramWr.addr = ramAddr[`CRAM_ADDR_WIDTH-1:0];
  assign cramWr.data = cramPayload;
  assign dramWr.addr = ramAddr[`DRAM_ADDR_WIDTH-1:0];
  assign dramWr.data = dramPayload;

  ////////////////////////////////////////
  // Line FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= stType;
      recKind <= recCram;
      sum <= '0;
      ramAddr <= '0;
      endLine <= 1'b0;
      cramWrValid <= 1'b0;
      dramWrValid <= 1'b0;
      lineDone <= 1'b0;
      lineError <= 1'b0;
      loadEnd <= 1'b0;
    end else begin
      lineDone <= 1'b0;
      lineError <= 1'b0;
      loadEnd <= 1'b0;
      // Newline before the checksum
      if (takeEol && (state inside {stCount, stAddress, stData})) begin
        lineDone <= 1'b1;
        lineError <= 1'b1;
        state <= stType;
      end
      case (state)
        stType: begin
          if (take && (token.kind == typeChar)) begin
            endLine <= 1'b0;
            if (token.recType == "C") begin
              recKind <= recCram;
              state <= stCount;
            end else if (token.recType == "D") begin
              recKind <= recDram;
              state <= stCount;
            end else if (token.recType == `CHAR_SEMICOLON) begin
              recKind <= recComment;
              state <= stSkip;
            end else begin
              recKind <= recUnknown;
              state <= stSkip;
            end
          end
        end
        stCount: begin
          if (takeField) begin
            sum <= token.value;
            // End of file line carries no checksum
            if (token.value == '0) begin
              endLine <= 1'b1;
              state <= stSkip;
            end else begin
              state <= stAddress;
            end
          end
        end
        stAddress: begin
          if (takeField) begin
            sum <= sum + token.value;
            ramAddr <= token.value;
            state <= stData;
          end
        end
        stData: begin
          if (takeField) begin
            sum <= sum + token.value;
            if (dataDone) begin
              // This field was the checksum
              state <= stChecksum;
            end else if (groupDone) begin
              // Payload is complete on the next clock
              if (recKind == recDram) begin
                dramWrValid <= 1'b1;
              end else begin
                cramWrValid <= 1'b1;
              end
              state <= stWriteWait;
            end
          end
        end
        stChecksum: begin
          // Good line sums to zero
          if (takeEol) begin
            lineDone <= 1'b1;
            lineError <= (sum != '0);
            state <= stType;
          end
        end
        stSkip: begin
          // Comment lines end silently
          if (takeEol) begin
            lineDone <= (recKind != recComment);
            lineError <= (recKind == recUnknown);
            loadEnd <= endLine;
            state <= stType;
          end
        end
        stWriteWait: begin
          if (wrTake) begin
            cramWrValid <= 1'b0;
            dramWrValid <= 1'b0;
            // One step per CRAM word and two per DRAM pair
            if (recKind == recDram) begin
              ramAddr <= ramAddr + 16'd2;
            end else begin
              ramAddr <= ramAddr + 16'd1;
            end
            state <= stData;
          end
        end
        default: begin
          state <= stType;
        end
      endcase
    end
  end

endmodule

// ==== verilog/wordAssembler.sv ====
// Shift register that gathers decoded field words into one RAM payload
`include "klLoader_cfg.svh"

module wordAssembler #(
  parameter type tPayload = klLoaderPkg::tDramPair
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   shiftEn,
  input  klLoaderPkg::tFieldWord fieldWord,
  output tPayload                payload
);

  import klLoaderPkg::*;

  // Field words needed to cover the payload
  localparam int numWords = ($bits(tPayload) + `FIELD_WIDTH - 1) / `FIELD_WIDTH;
  localparam int regWidth = numWords * `FIELD_WIDTH;

  // Oldest word ends up at the top
  logic [regWidth-1:0] shiftReg;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      shiftReg <= '0;
    end else if (shiftEn) begin
      shiftReg <= {shiftReg[regWidth-`FIELD_WIDTH-1:0], fieldWord};
    end
  end

  ////////////////////////////////////////
  // Payload placement
  ////////////////////////////////////////

  if ($bits(tPayload) == `CRAM_WORD_WIDTH) begin : gCramPlace
    tCramWord cramWord;

    // Load file order is 64-79, 48-63, 32-47, 16-31, 0-15 then 80-85
    always_comb begin
      cramWord[64:79] = shiftReg[95:80];
      cramWord[48:63] = shiftReg[79:64];
      cramWord[32:47] = shiftReg[63:48];
      cramWord[16:31] = shiftReg[47:32];
      cramWord[0:15] = shiftReg[31:16];
      // CALL and DISP special field
      cramWord[80:85] = shiftReg[5:0];
    end

    assign payload = tPayload'(cramWord);
  end else begin : gPlainPlace
    // Even, odd, common in arrival order
    assign payload = tPayload'(shiftReg);
  end

endmodule
